// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module sprite_tb -o sprite_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sprite_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1

// ==== test/sprite_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

// renderer fsm and hsync checks, bound into the top level
module sprite_sva import sprite_pkg::*; #(
	parameter int h_sync = 96
) (
	input logic          clk,
	input logic          reset,
	input logic          hsync,
	input logic          gfx,
	input logic          in_progress,
	input render_state_t state,
	input logic [3:0]    xcount,
	input logic [3:0]    ycount
);

	int hs_len; // high cycles of the current or last hsync pulse

	always_ff @(posedge clk) begin
		if (reset)
			hs_len <= 0;
		else if (hsync)
			hs_len <= hs_len + 1;
		else
			hs_len <= 0; // cleared one cycle after the fall
	end

	// gfx is registered, so it trails the draw state by one cycle
	gfx_after_draw: assert property (@(posedge clk) disable iff (reset)
		gfx |-> $past(state) == draw) else $error("gfx high without a draw cycle before it");

	state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {wait_vstart, wait_load, load_setup, load_fetch, wait_hstart, draw})
		else $error("renderer state holds an unused encoding");

	// first low cycle still sees the full count
	hsync_width: assert property (@(posedge clk) disable iff (reset)
		(!hsync && hs_len != 0) |-> hs_len == h_sync) else $error("hsync pulse width wrong");

	busy_end: assert property (@(posedge clk) disable iff (reset)
		(!in_progress && $past(in_progress)) |->
		($past(state) == draw && $past(xcount) == 4'd15 && $past(ycount) == 4'd15))
		else $error("in_progress dropped before the last pixel of row 15");

endmodule

bind sprite_video_top sprite_sva #(.h_sync(h_sync)) sva0 (
	.clk(clk), .reset(reset), .hsync(hsync), .gfx(gfx), .in_progress(in_progress),
	.state(render0.state), .xcount(render0.xcount), .ycount(render0.ycount)
);

`default_nettype wire

// ==== test/sprite_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_tb;

	localparam int h_total   = 60; // 48 + 4 + 4 + 4
	localparam int v_total   = 46; // 40 + 2 + 2 + 2
	localparam int h_vis     = 48;
	localparam int v_vis     = 40;
	localparam int vs_line   = 42; // first vsync line
	localparam int hs_first  = 52; // first hsync pixel
	localparam int tick_div  = 50;
	localparam int frame_len = h_total * v_total;

	logic       clk;
	logic       reset;
	logic       left;
	logic       right;
	logic       up;
	logic       down;
	logic       hsync;
	logic       vsync;
	logic [2:0] rgb;

	logic [7:0] rows [0:15];        // expected left half, bit c = column c
	logic [3:0] vec_mask [$];       // {left, right, up, down}
	int         vec_ticks [$];
	int         vec_x [$];
	int         vec_y [$];
	logic [4:0] frame [0:frame_len-1]; // {vsync, hsync, rgb}, row major
	int         cyc;                // clocks since reset release
	int         errors;
	int         tests_run;
	int         tests_failed;

	sprite_video_top #(
		.h_display(48), .h_front(4), .h_sync(4), .h_back(4),
		.v_display(40), .v_front(2), .v_sync(2), .v_back(2),
		.tick_div(tick_div)
	) dut0 (.clk(clk), .reset(reset), .left(left), .right(right), .up(up), .down(down),
		.hsync(hsync), .vsync(vsync), .rgb(rgb));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// tick_count in the dut tracks this mod tick_div
	always @(posedge clk) begin
		if (reset)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	task automatic load_vectors();
		int fd, n, m, t, x, y, nrows;
		string line;
		fd = $fopen("test/sprite_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/sprite_vectors.txt");
			errors++;
			return;
		end
		nrows = 0;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line[0] == "#")
				continue;
			if (nrows < 16) begin
				if ($sscanf(line, "%h", m) == 1) begin
					rows[nrows] = 8'(m);
					nrows++;
				end
			end else if ($sscanf(line, "%h %d %d %d", m, t, x, y) == 4) begin
				vec_mask.push_back(4'(m));
				vec_ticks.push_back(t);
				vec_x.push_back(x);
				vec_y.push_back(y);
			end
		end
		$fclose(fd);
		if (nrows < 16 || vec_mask.size() == 0) begin
			$display("vector file too short, %0d rows and %0d moves", nrows, vec_mask.size());
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
		end
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic wait_vsync_rise();
		logic prev;
		logic found;
		int   n;
		prev  = 1'b1; // a pulse already running does not count
		found = 1'b0;
		n     = 0;
		while (!found && n < 2 * frame_len) begin
			@(negedge clk);
			found = vsync && !prev;
			prev  = vsync;
			n++;
		end
		if (!found) begin
			$display("timeout, no vsync rise within two frames");
			errors++;
		end
	endtask

	// sync=0 means the caller is already at pixel (0,0)
	task automatic capture_frame(input bit sync);
		int i;
		if (sync) begin
			wait_vsync_rise(); // now at pixel 0 of line vs_line
			repeat ((v_total - vs_line) * h_total - 1) @(negedge clk);
		end
		for (i = 0; i < frame_len; i++) begin
			@(negedge clk);
			frame[i] = {vsync, hsync, rgb};
		end
	endtask

	task automatic check_frame(input int x, input int y);
		int         v, h, r, c, shown;
		logic [2:0] got;
		logic [2:0] exp;
		logic       pix;
		shown = 0;
		for (v = 0; v < v_total; v++) begin
			for (h = 0; h < h_total; h++) begin
				got = frame[v * h_total + h][2:0];
				r   = v - y - 1; // bitmap row on this line
				c   = h - x - 2; // bitmap column, two clocks of pipeline
				pix = 1'b0;
				if (r >= 0 && r < 16 && c >= 0 && c < 16)
					pix = (c < 8) ? rows[r][c] : rows[r][15 - c]; // mirrored half
				exp = {1'b0, pix, pix};
				if (v >= y + 1 && v <= y + 15)
					exp[2] = 1'b1;
				else if (v == y)
					exp[2] = (h >= 1); // fsm leaves idle after pixel 0
				else if (v == y + 16)
					exp[2] = (h <= x + 16); // busy through the last draw cycle
				if (v >= v_vis || h >= h_vis)
					exp = 3'b000; // blanking
				if (got !== exp) begin
					errors++;
					if (shown < 4)
						$display("FAIL t=%0t rgb at (%0d,%0d) got %b expected %b",
							$time, h, v, got, exp);
					shown++;
				end
			end
		end
	endtask

	// hold a direction mask until the given number of ticks have passed
	task automatic hold_dirs(input logic [3:0] mask, input int ticks);
		int seen;
		int n;
		@(posedge clk);
		#1;
		{left, right, up, down} = mask;
		seen = 0;
		n    = 0;
		while (seen < ticks && n < (ticks + 2) * tick_div) begin
			@(negedge clk);
			if (cyc % tick_div == tick_div - 1)
				seen++; // move lands at the next edge
			n++;
		end
		@(posedge clk);
		#1;
		{left, right, up, down} = 4'b0000;
		if (seen < ticks) begin
			$display("timeout, only %0d of %0d ticks seen", seen, ticks);
			errors++;
		end
	endtask

	task automatic measure_sync(input bit sel, output int width, output int period);
		int   n, rises;
		logic cur, prev;
		width  = 0;
		period = 0;
		rises  = 0;
		n      = 0;
		prev   = 1'b1;
		while (rises < 2 && n < 3 * frame_len) begin
			@(negedge clk);
			cur = sel ? vsync : hsync;
			if (cur && !prev)
				rises++;
			if (rises == 1) begin
				period++;
				if (cur)
					width++;
			end
			prev = cur;
			n++;
		end
		if (rises < 2) begin
			$display("timeout, %s did not pulse twice", sel ? "vsync" : "hsync");
			errors++;
		end
	endtask

	initial begin
		int err0, w, p, i, k;
		reset        = 1'b1;
		left         = 1'b0;
		right        = 1'b0;
		up           = 1'b0;
		down         = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		load_vectors();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		capture_frame(1'b0); // frame 0 starts right at release
		err0 = errors;
		for (i = 0; i < hs_first; i++)
			if (frame[i] !== 5'b0) begin
				errors++;
				$display("FAIL t=%0t {vsync,hsync,rgb} cycle %0d got %b expected 00000",
					$time, i, frame[i]);
			end
		finish_test("outputs quiet after reset", err0);
		err0 = errors;
		check_frame(16, 12); // home position for 48x40
		finish_test("first frame bitmap and blue band", err0);
		err0 = errors;
		measure_sync(1'b0, w, p);
		check_value("hsync width", w, 4);
		check_value("hsync period", p, h_total);
		measure_sync(1'b1, w, p);
		check_value("vsync width", w, 2 * h_total);
		check_value("vsync period", p, frame_len);
		finish_test("sync timing", err0);
		for (k = 0; k < vec_mask.size(); k++) begin
			err0 = errors;
			hold_dirs(vec_mask[k], vec_ticks[k]);
			capture_frame(1'b1);
			check_frame(vec_x[k], vec_y[k]);
			finish_test($sformatf("move mask %h for %0d ticks to (%0d,%0d)", vec_mask[k],
				vec_ticks[k], vec_x[k], vec_y[k]), err0);
		end
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/sprite_vectors.txt ====
# 16 sprite rows in hex, bit c = column c; then moves: mask {left,right,up,down} hex, ticks, x, y
c0
f0
fc
fe
c6
86
bc
b8
b8
b8
bc
86
c6
fe
fc
78
8 20 0 12
4 40 30 12
2 15 30 0
1 30 30 23
a 5 25 23
6 3 28 23

// ==== verilog/beam_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// beam position and sync group shared by the raster consumers
interface beam_if import sprite_pkg::*; ();

	coord_t hpos;      // pixel within the line
	coord_t vpos;      // line within the frame
	logic   hsync;
	logic   vsync;
	logic   display_on; // inside the visible area

	// driven by the raster generator only
	modport timing (output hpos, vpos, hsync, vsync, display_on);

	// everyone else just looks
	modport watch (input hpos, vpos, hsync, vsync, display_on);

endinterface

`default_nettype wire

// ==== verilog/player_position.sv ====
`timescale 1ns/1ps
`default_nettype none

// joystick position, moved on each tick, copied out at the vsync rise
module player_position import sprite_pkg::*; #(
	parameter int tick_div  = 250000,
	parameter int h_display = 640,
	parameter int v_display = 480
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   left,
	input  logic   right,
	input  logic   up,
	input  logic   down,
	beam_if.watch  beam,
	output coord_t player_x, // display position, stable for a whole frame
	output coord_t player_y
);

	localparam int tw = (tick_div > 1) ? $clog2(tick_div) : 1;

	// limits keep the whole sprite on screen incl the 2 pixel draw offset
	localparam coord_t x_max  = coord_t'(h_display - SPRITE_SIZE - 2);
	localparam coord_t y_max  = coord_t'(v_display - SPRITE_SIZE - 1);
	localparam coord_t x_home = coord_t'(h_display / 2 - SPRITE_SIZE / 2);
	localparam coord_t y_home = coord_t'(v_display / 2 - SPRITE_SIZE / 2);

	logic [tw-1:0] tick_count;
	logic          tick;
	logic          vsync_q;
	logic          vsync_rise;
	coord_t        joy_x;
	coord_t        joy_y;

	assign tick       = (tick_count == tw'(tick_div - 1)); // one cycle in tick_div
	assign vsync_rise = beam.vsync & ~vsync_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			tick_count <= '0;
			vsync_q    <= 1'b0;
			joy_x      <= x_home;
			joy_y      <= y_home;
			player_x   <= x_home;
			player_y   <= y_home;
		end else begin
			tick_count <= tick ? '0 : tick_count + 1'b1;
			vsync_q    <= beam.vsync;
			if (tick) begin
				// one step per tick, blocked moves fall through to the next key
				if (left && joy_x != '0)
					joy_x <= joy_x - 10'd1;
				else if (right && joy_x != x_max)
					joy_x <= joy_x + 10'd1;
				else if (up && joy_y != '0)
					joy_y <= joy_y - 10'd1;
				else if (down && joy_y != y_max)
					joy_y <= joy_y + 10'd1;
			end
			if (vsync_rise) begin
				player_x <= joy_x; // beam is off screen, no tearing
				player_y <= joy_y;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sprite_pkg.sv ====
`default_nettype none

package sprite_pkg;

	// screen coordinate, 10 bits covers the 800x525 vga raster
	typedef logic [9:0] coord_t;

	// one bitmap row of the left half, bit c is column c
	typedef logic [7:0] sprite_row_t;

	localparam int SPRITE_SIZE = 16; // width and height in pixels

	// renderer fsm encoding
	typedef enum logic [2:0] {
		wait_vstart = 3'd0, // idle until the beam reaches the sprite top
		wait_load   = 3'd1, // wait for hsync to fetch the next row
		load_setup  = 3'd2, // present row address to the rom
		load_fetch  = 3'd3, // latch the row bits
		wait_hstart = 3'd4, // wait for the left edge on the next line
		draw        = 3'd5  // shift out 16 mirrored pixels
	} render_state_t;

endpackage

`default_nettype wire

// ==== verilog/sprite_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none

// 16x16 sprite, rows fetched in hsync, drawn mirrored left to right
module sprite_renderer import sprite_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        vstart,   // beam on the sprite's top line
	input  logic        load,     // hsync, safe window for the rom fetch
	input  logic        hstart,   // beam on the sprite's left column
	output logic [3:0]  rom_addr,
	input  sprite_row_t rom_bits,
	output logic        gfx,      // registered pixel
	output logic        in_progress
);

	render_state_t state;
	logic [3:0]    ycount;   // rows done so far
	logic [3:0]    xcount;   // pixels of this row done so far
	sprite_row_t   row_bits; // current row, held through draw
	logic [2:0]    pix_sel;

	// right half walks the row backwards, 15-xcount
	assign pix_sel = xcount[3] ? ~xcount[2:0] : xcount[2:0];

	assign in_progress = (state != wait_vstart);

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= wait_vstart;
			gfx    <= 1'b0;
			ycount <= '0;
			xcount <= '0;
		end else begin
			gfx <= 1'b0; // dark unless drawing
			case (state)
				wait_vstart: begin
					ycount <= '0;
					if (vstart)
						state <= wait_load;
				end
				wait_load: begin
					xcount <= '0;
					if (load)
						state <= load_setup;
				end
				load_setup: begin
					state <= load_fetch; // rom_addr goes out this edge
				end
				load_fetch: begin
					state <= wait_hstart; // row_bits latched this edge
				end
				wait_hstart: begin
					if (hstart)
						state <= draw;
				end
				draw: begin
					gfx    <= row_bits[pix_sel];
					xcount <= xcount + 4'd1;
					if (xcount == 4'(SPRITE_SIZE - 1)) begin
						ycount <= ycount + 4'd1;
						// ycount still holds the row just drawn
						if (ycount == 4'(SPRITE_SIZE - 1))
							state <= wait_vstart;
						else
							state <= wait_load;
					end
				end
				default: begin
					state <= wait_vstart; // unused codes fall back to idle
				end
			endcase
		end
	end

	// rom address and row latch
	always_ff @(posedge clk) begin
		if (state == load_setup)
			rom_addr <= ycount;
		if (state == load_fetch)
			row_bits <= rom_bits; // rom is combinational, ready one cycle on
	end

endmodule

`default_nettype wire

// ==== verilog/sprite_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

// car pattern, left half only, renderer mirrors it for the right half
module sprite_rom import sprite_pkg::*; (
	input  logic [3:0]  addr, // sprite row
	output sprite_row_t bits
);

	always_comb begin
		case (addr)
			4'd0:    bits = 8'b1100_0000; // nose
			4'd1:    bits = 8'b1111_0000;
			4'd2:    bits = 8'b1111_1100; // front bumper
			4'd3:    bits = 8'b1111_1110;
			4'd4:    bits = 8'b1100_0110; // front wheels poke out
			4'd5:    bits = 8'b1000_0110;
			4'd6:    bits = 8'b1011_1100; // windscreen
			4'd7:    bits = 8'b1011_1000;
			4'd8:    bits = 8'b1011_1000; // roof
			4'd9:    bits = 8'b1011_1000;
			4'd10:   bits = 8'b1011_1100;
			4'd11:   bits = 8'b1000_0110; // rear wheels
			4'd12:   bits = 8'b1100_0110;
			4'd13:   bits = 8'b1111_1110;
			4'd14:   bits = 8'b1111_1100; // tail
			default: bits = 8'b0111_1000; // row 15, exhaust stubs
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/sprite_video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// raster, player position and sprite renderer glued into 3-bit rgb
module sprite_video_top import sprite_pkg::*; #(
	parameter int h_display = 640,
	parameter int h_front   = 16,
	parameter int h_sync    = 96,
	parameter int h_back    = 48,
	parameter int v_display = 480,
	parameter int v_front   = 10,
	parameter int v_sync    = 2,
	parameter int v_back    = 33,
	parameter int tick_div  = 250000 // 100 Hz moves at 25 MHz
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       left,
	input  logic       right,
	input  logic       up,
	input  logic       down,
	output logic       hsync,
	output logic       vsync,
	output logic [2:0] rgb // {blue, green, red}
);

	coord_t      player_x;
	coord_t      player_y;
	logic        vstart;
	logic        hstart;
	logic [3:0]  rom_addr;
	sprite_row_t rom_bits;
	logic        gfx;
	logic        in_progress;

	beam_if beam ();

	video_timing #(
		.h_display(h_display), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
		.v_display(v_display), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
	) timing0 (.clk(clk), .reset(reset), .beam(beam));

	player_position #(.tick_div(tick_div), .h_display(h_display), .v_display(v_display))
		pos0 (.clk(clk), .reset(reset), .left(left), .right(right), .up(up), .down(down),
			.beam(beam), .player_x(player_x), .player_y(player_y));

	assign vstart = (beam.vpos == player_y); // whole top line
	assign hstart = (beam.hpos == player_x); // one cycle per line

	sprite_renderer render0 (.clk(clk), .reset(reset), .vstart(vstart), .load(beam.hsync),
		.hstart(hstart), .rom_addr(rom_addr), .rom_bits(rom_bits), .gfx(gfx),
		.in_progress(in_progress));

	sprite_rom rom0 (.addr(rom_addr), .bits(rom_bits));

	assign hsync = beam.hsync;
	assign vsync = beam.vsync;
	// red and green share the pixel, blue marks the rendering band
	assign rgb   = {beam.display_on & in_progress, beam.display_on & gfx, beam.display_on & gfx};

endmodule

`default_nettype wire

// ==== verilog/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running raster counters, syncs decoded straight off the count
module video_timing import sprite_pkg::*; #(
	parameter int h_display = 640,
	parameter int h_front   = 16,
	parameter int h_sync    = 96,
	parameter int h_back    = 48,
	parameter int v_display = 480,
	parameter int v_front   = 10,
	parameter int v_sync    = 2,
	parameter int v_back    = 33
) (
	input  logic    clk,
	input  logic    reset,
	beam_if.timing  beam
);

	localparam int h_total = h_display + h_front + h_sync + h_back;
	localparam int v_total = v_display + v_front + v_sync + v_back;

	localparam coord_t h_last   = coord_t'(h_total - 1);
	localparam coord_t v_last   = coord_t'(v_total - 1);
	localparam coord_t hs_start = coord_t'(h_display + h_front); // first sync pixel
	localparam coord_t hs_end   = coord_t'(h_display + h_front + h_sync); // one past
	localparam coord_t vs_start = coord_t'(v_display + v_front);
	localparam coord_t vs_end   = coord_t'(v_display + v_front + v_sync);

	coord_t hcount;
	coord_t vcount;

	always_ff @(posedge clk) begin
		if (reset) begin
			hcount <= '0;
			vcount <= '0;
		end else if (hcount == h_last) begin
			hcount <= '0; // end of line, step to the next one
			vcount <= (vcount == v_last) ? '0 : vcount + 10'd1;
		end else begin
			hcount <= hcount + 10'd1;
		end
	end

	assign beam.hpos       = hcount;
	assign beam.vpos       = vcount;
	assign beam.hsync      = (hcount >= hs_start) && (hcount < hs_end);
	assign beam.vsync      = (vcount >= vs_start) && (vcount < vs_end);
	assign beam.display_on = (hcount < coord_t'(h_display)) && (vcount < coord_t'(v_display));

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/sprite_pkg.sv
verilog/beam_if.sv
verilog/video_timing.sv
verilog/sprite_rom.sv
verilog/player_position.sv
verilog/sprite_renderer.sv
verilog/sprite_video_top.sv
test/sprite_sva.sv
test/sprite_tb.sv
